// ==== src/erx_pkg.sv ====
package erx_pkg;

   //####################################################################
   // Link geometry
   //####################################################################
   localparam int word_w = 64;        // Parallel word from the deserializer
   localparam int lanes  = 8;         // Byte lanes, one frame bit per lane
   localparam int byte_w = 8;         // Width of one byte lane
   localparam int gpio_w = 9;         // Frame bit on top of data byte 0
   localparam int ctrl_w = 8;         // Control byte of a transaction
   localparam int addr_w = 32;        // Address and data field width

   //####################################################################
   // Receive FIFOs
   //####################################################################
   localparam int fifo_depth = 16;    // Entries per FIFO, power of two

   // Wait goes up with 4 slots still free, enough for the pairs
   // already inside the input pipeline when the sender sees it
   localparam int fifo_afull = 12;

   localparam int fifo_aw = $clog2(fifo_depth);   // Pointer width

   //####################################################################
   // Control byte fields
   //####################################################################
   localparam int ctrl_write_bit = 0; // 1 = write, 0 = read request
   localparam int ctrl_size_lsb  = 2; // 2-bit size field, bits 3:2

   //####################################################################
   // Transactions as they leave the assembler
   //####################################################################

   // Write: address and data carried in the word pair
   typedef struct packed
   {
      logic [ctrl_w-1:0] ctrl;        // Raw control byte
      logic [addr_w-1:0] dstaddr;     // Target address
      logic [addr_w-1:0] data;        // Write data
   } wr_trans_t;

   // Read request: srcaddr is where the reply goes back to
   typedef struct packed
   {
      logic [ctrl_w-1:0] ctrl;        // Raw control byte
      logic [addr_w-1:0] dstaddr;     // Address to read
      logic [addr_w-1:0] srcaddr;     // Return address
   } rd_trans_t;

endpackage

// ==== src/erx_io.sv ====
`timescale 1ns/1ps

module erx_io
   import erx_pkg::*;
(
   input  logic              rx_lclk_div4,
   input  logic              rxreset,
   input  logic [lanes-1:0]  rx_frame_des,     // Frame vector from deserializer
   input  logic [word_w-1:0] rx_data_des,      // Eight byte lanes
   input  logic              ecfg_rx_enable,   // Link enable, other domain
   input  logic              ecfg_rx_gpio_enable, // GPIO mode, other domain
   input  logic [1:0]        ecfg_dataout,     // Bit 0 rd_wait, bit 1 wr_wait
   input  logic              fifo_wr_wait,     // Write FIFO almost full
   input  logic              fifo_rd_wait,     // Read FIFO almost full
   output logic [lanes-1:0]  rx_frame_par,
   output logic [word_w-1:0] rx_data_par,
   output logic [gpio_w-1:0] ecfg_rx_datain,   // GPIO sample
   output logic              rx_wr_wait,
   output logic              rx_rd_wait
);

   logic [1:0]        rxenb_sync;    // Enable synchronizer chain
   logic [1:0]        rxgpio_sync;   // GPIO mode synchronizer chain
   logic              rx_en;         // Enable in effect
   logic              gpio_on;       // GPIO mode in effect
   logic [word_w-1:0] rx_data_reg;   // First data stage
   logic [lanes-1:0]  rx_frame_reg;  // First frame stage, gated

   //####################################################################
   // Control synchronizers
   //####################################################################
   always_ff @(posedge rx_lclk_div4 or posedge rxreset)
   begin
      if (rxreset)
      begin
         rxenb_sync  <= '0;
         rxgpio_sync <= '0;
      end
      else
      begin
         rxenb_sync  <= {rxenb_sync[0], ecfg_rx_enable};
         rxgpio_sync <= {rxgpio_sync[0], ecfg_rx_gpio_enable};
      end
   end

   assign rx_en   = rxenb_sync[1];
   assign gpio_on = rxgpio_sync[1];

   //####################################################################
   // Two-stage word and frame registering
   //####################################################################

   // Frame is dropped at the first stage unless the link is live
   always_ff @(posedge rx_lclk_div4 or posedge rxreset)
   begin
      if (rxreset)
      begin
         rx_frame_reg <= '0;
         rx_frame_par <= '0;
      end
      else
      begin
         rx_frame_reg <= rx_frame_des & {lanes{rx_en & ~gpio_on}};
         rx_frame_par <= rx_frame_reg;
      end
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      rx_data_reg    <= rx_data_des;
      rx_data_par    <= rx_data_reg;
      ecfg_rx_datain <= {rx_frame_par[0], rx_data_par[byte_w-1:0]}; // GPIO sample
   end

   // Wait lines, constants from config in GPIO mode
   assign rx_rd_wait = gpio_on ? ecfg_dataout[0] : fifo_rd_wait;
   assign rx_wr_wait = gpio_on ? ecfg_dataout[1] : fifo_wr_wait;

endmodule

// ==== src/erx_protocol.sv ====
`timescale 1ns/1ps

module erx_protocol
   import erx_pkg::*;
(
   input  logic              rx_lclk_div4,
   input  logic              rxreset,
   input  logic [lanes-1:0]  rx_frame_par,   // Word-aligned frame, all lanes equal
   input  logic [word_w-1:0] rx_data_par,
   output logic              wr_strobe,      // One cycle per write transaction
   output wr_trans_t         wr_trans_in,
   output logic              rd_strobe,      // One cycle per read request
   output rd_trans_t         rd_trans_in
);

   logic              frame_on;    // Frame high on every lane
   logic              phase;       // 0 = expect first word, 1 = second
   logic              pair_done;   // Second word of a pair present now
   logic [word_w-1:0] first_word;  // Held first word of the pair
   logic [ctrl_w-1:0] ctrl;
   logic [addr_w-1:0] dstaddr;
   logic [addr_w-1:0] data_field;
   logic [addr_w-1:0] srcaddr;
   logic              is_write;

   assign frame_on  = &rx_frame_par;
   assign pair_done = frame_on & phase;

   //####################################################################
   // Pairing phase
   //####################################################################

   // Toggles on every framed word, a frame drop restarts the pair
   always_ff @(posedge rx_lclk_div4 or posedge rxreset)
   begin
      if (rxreset)
      begin
         phase <= 1'b0;
      end
      else if (!frame_on)
      begin
         phase <= 1'b0;                     // Half pair discarded
      end
      else
      begin
         phase <= ~phase;
      end
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      if (frame_on && !phase)
      begin
         first_word <= rx_data_par;         // Park first word
      end
   end

   //####################################################################
   // Field decode across the word pair
   //####################################################################
   assign ctrl       = first_word[byte_w-1:0];            // Byte 0
   assign dstaddr    = first_word[5*byte_w-1:byte_w];     // Bytes 1-4, LS first

   // Low three data bytes ride in the first word, the top one in the second
   assign data_field = {rx_data_par[byte_w-1:0], first_word[word_w-1:5*byte_w]};

   assign srcaddr    = rx_data_par[5*byte_w-1:byte_w];    // Second word, bytes 1-4
   assign is_write   = ctrl[ctrl_write_bit];

   //####################################################################
   // Transaction outputs
   //####################################################################
   always_ff @(posedge rx_lclk_div4 or posedge rxreset)
   begin
      if (rxreset)
      begin
         wr_strobe <= 1'b0;
         rd_strobe <= 1'b0;
      end
      else
      begin
         wr_strobe <= pair_done & is_write;
         rd_strobe <= pair_done & ~is_write;  // Mutually exclusive by ctrl bit
      end
   end

   // Both payloads load together, only one strobe says which is real
   always_ff @(posedge rx_lclk_div4)
   begin
      if (pair_done)
      begin
         wr_trans_in.ctrl    <= ctrl;
         wr_trans_in.dstaddr <= dstaddr;
         wr_trans_in.data    <= data_field;   // srcaddr ignored for writes
         rd_trans_in.ctrl    <= ctrl;
         rd_trans_in.dstaddr <= dstaddr;
         rd_trans_in.srcaddr <= srcaddr;      // Data ignored for reads
      end
   end

endmodule

// ==== src/erx_fifo.sv ====
`timescale 1ns/1ps

module erx_fifo
   import erx_pkg::*;
#(
   parameter type payload_t = wr_trans_t   // Transaction type held per entry
)
(
   input  logic     rx_lclk_div4,
   input  logic     rxreset,
   input  logic     push,     // Write strobe, dropped while full
   input  payload_t din,
   input  logic     pop,      // Advance head, ignored while empty
   output payload_t dout,     // Show-ahead head entry
   output logic     empty,
   output logic     afull     // Becomes the wait line
);

   payload_t           mem [fifo_depth];  // Entry storage
   logic [fifo_aw-1:0] wr_ptr;
   logic [fifo_aw-1:0] rd_ptr;
   logic [fifo_aw:0]   count;              // 0 to fifo_depth entries
   logic               full;
   logic               wr_en;
   logic               rd_en;

   assign wr_en = push & ~full;
   assign rd_en = pop & ~empty;

   //####################################################################
   // Pointers and fill count
   //####################################################################

   // Pointers wrap by themselves, depth is a power of two
   always_ff @(posedge rx_lclk_div4 or posedge rxreset)
   begin
      if (rxreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         unique case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;       // Idle or push and pop together
         endcase
      end
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      if (wr_en)
      begin
         mem[wr_ptr] <= din;
      end
   end

   //####################################################################
   // Flags and head
   //####################################################################
   assign dout  = mem[rd_ptr];             // Valid whenever empty is low
   assign empty = (count == '0);
   assign full  = (count == fifo_depth);
   assign afull = (count >= fifo_afull);

endmodule

// ==== src/erx_top.sv ====
`timescale 1ns/1ps

module erx_top
   import erx_pkg::*;
(
   input  logic              rx_lclk_div4,
   input  logic              rxreset,
   input  logic [lanes-1:0]  rx_frame_des,
   input  logic [word_w-1:0] rx_data_des,
   input  logic              ecfg_rx_enable,
   input  logic              ecfg_rx_gpio_enable,
   input  logic [1:0]        ecfg_dataout,
   input  logic              wr_pop,          // Consumer pops write FIFO
   input  logic              rd_pop,          // Consumer pops read FIFO
   output logic              rx_wr_wait,
   output logic              rx_rd_wait,
   output logic [gpio_w-1:0] ecfg_rx_datain,
   output wr_trans_t         wr_trans,        // Write FIFO head
   output logic              wr_empty,
   output rd_trans_t         rd_trans,        // Read FIFO head
   output logic              rd_empty
);

   logic [lanes-1:0]  rx_frame_par;
   logic [word_w-1:0] rx_data_par;
   logic              wr_strobe;
   logic              rd_strobe;
   wr_trans_t         wr_trans_in;
   rd_trans_t         rd_trans_in;
   logic              fifo_wr_wait;
   logic              fifo_rd_wait;

   //####################################################################
   // Input side
   //####################################################################
   erx_io u_io
   (
      .rx_lclk_div4        (rx_lclk_div4),
      .rxreset             (rxreset),
      .rx_frame_des        (rx_frame_des),
      .rx_data_des         (rx_data_des),
      .ecfg_rx_enable      (ecfg_rx_enable),
      .ecfg_rx_gpio_enable (ecfg_rx_gpio_enable),
      .ecfg_dataout        (ecfg_dataout),
      .fifo_wr_wait        (fifo_wr_wait),
      .fifo_rd_wait        (fifo_rd_wait),
      .rx_frame_par        (rx_frame_par),
      .rx_data_par         (rx_data_par),
      .ecfg_rx_datain      (ecfg_rx_datain),
      .rx_wr_wait          (rx_wr_wait),
      .rx_rd_wait          (rx_rd_wait)
   );

   // Word pairs to transactions
   erx_protocol u_protocol
   (
      .rx_lclk_div4 (rx_lclk_div4),
      .rxreset      (rxreset),
      .rx_frame_par (rx_frame_par),
      .rx_data_par  (rx_data_par),
      .wr_strobe    (wr_strobe),
      .wr_trans_in  (wr_trans_in),
      .rd_strobe    (rd_strobe),
      .rd_trans_in  (rd_trans_in)
   );

   //####################################################################
   // Output FIFOs, almost full feeds back as wait
   //####################################################################
   erx_fifo #(.payload_t(wr_trans_t)) u_wr_fifo
   (
      .rx_lclk_div4 (rx_lclk_div4),
      .rxreset      (rxreset),
      .push         (wr_strobe),
      .din          (wr_trans_in),
      .pop          (wr_pop),
      .dout         (wr_trans),
      .empty        (wr_empty),
      .afull        (fifo_wr_wait)
   );

   erx_fifo #(.payload_t(rd_trans_t)) u_rd_fifo
   (
      .rx_lclk_div4 (rx_lclk_div4),
      .rxreset      (rxreset),
      .push         (rd_strobe),
      .din          (rd_trans_in),
      .pop          (rd_pop),
      .dout         (rd_trans),
      .empty        (rd_empty),
      .afull        (fifo_rd_wait)
   );

endmodule

// ==== sim/erx_chk.sv ====
`timescale 1ns/1ps

module erx_chk
(
   input logic clk,
   input logic rst,
   input logic push,        // FIFO write strobe
   input logic full,
   input logic pop,         // FIFO read strobe
   input logic empty,
   input logic frame,       // Assembler sees a framed word
   input logic wr_strobe,   // Assembler outputs
   input logic rd_strobe
);

   // A push while full loses the transaction
   a_push_full : assert property (@(posedge clk) disable iff (rst) !(push && full))
      else $error("Push into a full FIFO, transaction dropped");

   a_pop_empty : assert property (@(posedge clk) disable iff (rst) !(pop && empty))
      else $error("Pop from an empty FIFO");

   // Every transaction comes from two framed words in a row
   a_pair_framed : assert property (@(posedge clk) disable iff (rst)
      (wr_strobe || rd_strobe) |-> $past(frame, 1) && $past(frame, 2))
      else $error("Transaction strobe without a framed word pair ahead of it");

endmodule

bind erx_fifo erx_chk u_chk
(
   .clk (rx_lclk_div4), .rst (rxreset), .push (push), .full (full),
   .pop (pop), .empty (empty), .frame (1'b0), .wr_strobe (1'b0), .rd_strobe (1'b0)
);

bind erx_protocol erx_chk u_chk
(
   .clk (rx_lclk_div4), .rst (rxreset), .push (1'b0), .full (1'b0),
   .pop (1'b0), .empty (1'b0), .frame (frame_on),
   .wr_strobe (wr_strobe), .rd_strobe (rd_strobe)
);

// ==== sim/erx_tb.sv ====
`timescale 1ns/1ps

module erx_tb
   import erx_pkg::*;
();

   logic              rx_lclk_div4;
   logic              rxreset;
   logic [lanes-1:0]  rx_frame_des;
   logic [word_w-1:0] rx_data_des;
   logic              ecfg_rx_enable;
   logic              ecfg_rx_gpio_enable;
   logic [1:0]        ecfg_dataout;
   logic              wr_pop;
   logic              rd_pop;
   logic              rx_wr_wait;
   logic              rx_rd_wait;
   logic [gpio_w-1:0] ecfg_rx_datain;
   wr_trans_t         wr_trans;
   logic              wr_empty;
   rd_trans_t         rd_trans;
   logic              rd_empty;

   logic [4:0]        cyc_ctl[$];      // {gpio, en, dataout, stall} per cycle
   logic [lanes-1:0]  cyc_frame[$];
   logic [word_w-1:0] cyc_data[$];
   logic [gpio_w-1:0] gpio_exp[int];   // Keyed by drive cycle
   wr_trans_t         wr_exp[$];
   rd_trans_t         rd_exp[$];
   int err_wr = 0, err_rd = 0, err_gpio = 0, err_other = 0;
   int cycles = 0, limit = 0, drv_n = 0;
   int stall_left = 0;                 // Stalled words still on their way to the FIFOs
   bit checking = 0, saw_wr_wait = 0;
   bit e_wr = 1, e_rd = 1;             // Empty flags seen at the last falling edge

   erx_top u_dut (.*);

   initial rx_lclk_div4 = 1'b0;
   always #20 rx_lclk_div4 = ~rx_lclk_div4;   // 40 ns period

   //######################################################################
   // Compare tasks
   //######################################################################
   task automatic check_wr(input string name, input wr_trans_t exp, input wr_trans_t act);
      if (act !== exp)
      begin
         $display("ERROR %s: expected %h actual %h", name, exp, act);
         err_wr++;
      end
   endtask

   task automatic check_rd(input string name, input rd_trans_t exp, input rd_trans_t act);
      if (act !== exp)
      begin
         $display("ERROR %s: expected %h actual %h", name, exp, act);
         err_rd++;
      end
   endtask

   task automatic check_gpio(input string name, input logic [gpio_w-1:0] exp,
                             input logic [gpio_w-1:0] act);
      if (act !== exp)
      begin
         $display("ERROR %s: expected %h actual %h", name, exp, act);
         err_gpio++;
      end
   endtask

   // Pairs are {wr, rd}
   task automatic check_wait(input string name, input logic [1:0] exp, input logic [1:0] act);
      if (act !== exp)
      begin
         $display("ERROR %s: expected %b actual %b", name, exp, act);
         err_other++;
      end
   endtask

   task automatic check_empty(input string name, input logic [1:0] exp, input logic [1:0] act);
      if (act !== exp)
      begin
         $display("ERROR %s: expected %b actual %b", name, exp, act);
         err_other++;
      end
   endtask

   //######################################################################
   // Pattern file and drive
   //######################################################################
   task automatic load_patterns();
      int fd, rep, gp, en, dout, stall, code;
      string line;
      logic [lanes-1:0] frm;
      logic [word_w-1:0] dat;
      logic [31:0] c, a, b;
      wr_trans_t w;
      rd_trans_t r;
      fd = $fopen("sim/erx_patterns.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open the pattern file sim/erx_patterns.txt");
         err_other++;
         return;
      end
      while (!$feof(fd))
      begin
         code = $fgets(line, fd);
         if (code <= 0 || line.len() < 2)
            continue;
         if (line.getc(0) == "D")
         begin
            code = $sscanf(line, "D %d %d %d %d %d %h %h", rep, gp, en, dout, stall, frm, dat);
            repeat (rep)
            begin
               cyc_ctl.push_back({gp[0], en[0], dout[1:0], stall[0]});
               cyc_frame.push_back(frm);
               cyc_data.push_back(dat);
            end
         end
         else if (line.getc(0) == "W")
         begin
            code = $sscanf(line, "W %d %h %h %h", rep, c, a, b);
            w.ctrl = c[7:0];
            w.dstaddr = a;
            w.data = b;
            repeat (rep) wr_exp.push_back(w);
         end
         else if (line.getc(0) == "R")
         begin
            code = $sscanf(line, "R %d %h %h %h", rep, c, a, b);
            r.ctrl = c[7:0];
            r.dstaddr = a;
            r.srcaddr = b;
            repeat (rep) rd_exp.push_back(r);
         end
         else if (line.getc(0) == "G")
         begin
            code = $sscanf(line, "G %h", c);
            gpio_exp[cyc_data.size() - 1] = c[gpio_w-1:0];   // Last D cycle so far
         end
      end
      $fclose(fd);
   endtask

   // Pops run every other cycle so each head is seen once before it moves
   task automatic drive_cycle(input logic [4:0] ctl, input logic [lanes-1:0] frm,
                              input logic [word_w-1:0] dat);
      ecfg_rx_gpio_enable <= ctl[4];
      ecfg_rx_enable      <= ctl[3];
      ecfg_dataout        <= ctl[2:1];
      rx_frame_des        <= frm;
      rx_data_des         <= dat;
      if (ctl[0])
         stall_left = 4;                  // Drive to FIFO write latency
      else if (stall_left > 0)
         stall_left--;
      wr_pop <= !wr_pop && !e_wr && stall_left == 0;
      rd_pop <= !rd_pop && !e_rd && stall_left == 0;
      drv_n++;
   endtask

   //######################################################################
   // Monitor at the falling edge
   //######################################################################
   always @(negedge rx_lclk_div4)
   begin
      if (checking)
      begin
         if (wr_pop && wr_exp.size() == 0)
         begin
            $display("Unexpected write transaction at the write FIFO head");
            err_wr++;
         end
         else if (wr_pop)
            check_wr("write", wr_exp.pop_front(), wr_trans);
         if (rd_pop && rd_exp.size() == 0)
         begin
            $display("Unexpected read transaction at the read FIFO head");
            err_rd++;
         end
         else if (rd_pop)
            check_rd("read", rd_exp.pop_front(), rd_trans);
         // Sample shows up 3 edges after its drive
         if (drv_n >= 4 && gpio_exp.exists(drv_n - 4))
         begin
            check_gpio("gpio sample", gpio_exp[drv_n - 4], ecfg_rx_datain);
            if (cyc_ctl[drv_n - 4][4])
               check_wait("gpio wait", cyc_ctl[drv_n - 4][2:1], {rx_wr_wait, rx_rd_wait});
         end
         if (rx_wr_wait && !ecfg_rx_gpio_enable)
            saw_wr_wait = 1;
         e_wr = wr_empty;
         e_rd = rd_empty;
      end
   end

   always @(posedge rx_lclk_div4)
   begin
      cycles++;
      if (limit > 0 && cycles > limit)
      begin
         $display("Timeout after %0d cycles with transactions still outstanding", cycles);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   //######################################################################
   // Main sequence
   //######################################################################
   initial
   begin
      rxreset             = 1'b1;
      rx_frame_des        = '0;
      rx_data_des         = '0;
      ecfg_rx_enable      = 1'b1;
      ecfg_rx_gpio_enable = 1'b0;
      ecfg_dataout        = 2'b00;
      wr_pop              = 1'b0;
      rd_pop              = 1'b0;
      load_patterns();
      limit = 2 * cyc_ctl.size() + 200;
      repeat (16) @(posedge rx_lclk_div4);
      rxreset <= 1'b0;
      @(negedge rx_lclk_div4);
      check_empty("reset empty", 2'b11, {wr_empty, rd_empty});
      check_wait("reset wait", 2'b00, {rx_wr_wait, rx_rd_wait});
      checking = 1;
      foreach (cyc_ctl[i])
      begin
         @(posedge rx_lclk_div4);
         drive_cycle(cyc_ctl[i], cyc_frame[i], cyc_data[i]);
      end
      // Drain, timeout catches anything that never arrives
      while (wr_exp.size() > 0 || rd_exp.size() > 0 || !e_wr || !e_rd)
      begin
         @(posedge rx_lclk_div4);
         drive_cycle(5'b01000, '0, '0);
         @(negedge rx_lclk_div4);
      end
      repeat (4)
      begin
         @(posedge rx_lclk_div4);
         drive_cycle(5'b01000, '0, '0);
      end
      @(negedge rx_lclk_div4);
      if (!saw_wr_wait)
      begin
         $display("Write wait line never rose while pops were stalled");
         err_other++;
      end
      check_wait("drained wait", 2'b00, {rx_wr_wait, rx_rd_wait});
      check_empty("drained empty", 2'b11, {wr_empty, rd_empty});
      $display("Errors: write %0d read %0d gpio %0d other %0d",
               err_wr, err_rd, err_gpio, err_other);
      if (err_wr + err_rd + err_gpio + err_other == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// ==== sim/erx_patterns.txt ====
# D rep gpio en dataout stall frame data : one drive line held for rep cycles, stall stops pops
# W|R rep ctrl dstaddr data|srcaddr : expected FIFO heads, G sample : GPIO word of the last D
D 4 0 1 0 0 00 0000000000000000
D 1 0 1 0 0 ff 2233448000100001
G 101
D 1 0 1 0 0 ff abcdef0000000011
W 1 01 80001000 11223344
D 1 0 1 0 0 00 0000000000000000
D 1 0 1 0 0 ff 0000008000200004
D 1 0 1 0 0 ff 0000004000004000
R 1 04 80002000 40000040
D 2 0 1 0 0 00 0000000000000000
D 1 0 1 0 0 ff 6655443000000305
D 1 0 1 0 0 ff 0000000000000077
D 1 0 1 0 0 ff 0000000000010008
D 1 0 1 0 0 ff 0000000000020000
D 1 0 1 0 0 ff fef00ddeadbeef0d
D 1 0 1 0 0 ff ffffff12121212ca
D 1 0 1 0 0 ff 1111111111111101
D 1 0 1 0 0 00 0000000000000000
D 1 0 1 0 0 ff 0000440000000401
D 1 0 1 0 0 ff 0000000000000000
W 1 05 30000003 77665544
R 1 08 00000100 00000200
W 1 0d deadbeef cafef00d
W 1 01 00000004 00000044
D 8 0 1 0 0 00 0000000000000000
D 24 0 1 0 1 ff 5a5a5a1234567801
W 12 01 12345678 015a5a5a
D 40 0 1 0 0 00 0000000000000000
D 3 1 1 1 0 00 0000000000000000
D 1 1 1 1 0 ff 2233448000100001
G 001
D 1 1 1 1 0 ff 00000000000000a5
G 0a5
D 4 1 1 1 0 00 0000000000000000
D 4 0 1 0 0 00 0000000000000000
D 3 0 0 0 0 00 0000000000000000
D 1 0 0 0 0 ff 2233448000100001
D 1 0 0 0 0 ff abcdef0000000011
D 3 0 1 0 0 00 0000000000000000
D 1 0 1 0 0 ff 0000550000cafe01
D 1 0 1 0 0 ff 0000000000000000
W 1 01 0000cafe 00000055
D 20 0 1 0 0 00 0000000000000000

// ==== all.f ====
src/erx_pkg.sv
src/erx_io.sv
src/erx_protocol.sv
src/erx_fifo.sv
src/erx_top.sv
sim/erx_chk.sv
sim/erx_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the receive link testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --top-module erx_tb -f all.f -o erx_sim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi
./obj_dir/erx_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi
if grep -q "CHECKS FAILED" sim.log; then
   exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
   echo "Simulation log has no pass line"
   exit 1
fi
exit 0
